// File: Bender.yml
package:
  name: stepper_controller

sources:
  - src/stepper_pkg.sv
  - src/dda_axis.sv
  - src/move_sequencer.sv
  - src/word_command_decoder.sv
  - src/stepper_controller_top.sv
  - target: test
    files:
      - verif/tb_stepper_controller.sv

// File: compile.f
src/stepper_pkg.sv
src/dda_axis.sv
src/move_sequencer.sv
src/word_command_decoder.sv
src/stepper_controller_top.sv
verif/tb_stepper_controller.sv

// File: src/dda_axis.sv
// Single axis DDA with acceleration, producing step pulses and a signed position count
`timescale 1ns/1ps

module dda_axis (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic                                  dda_tick,
  input  logic                                  loading,
  input  logic                                  executing,
  input  stepper_pkg::move_t                    move,
  output logic                                  step,
  output logic                                  dir,
  output logic [stepper_pkg::position_bits-1:0] position
);

  logic [stepper_pkg::dda_bits-1:0] velocity;
  logic [stepper_pkg::dda_bits-1:0] accumulator;
  logic [stepper_pkg::dda_bits-1:0] next_velocity;
  logic [stepper_pkg::dda_bits:0]   sum;  // Top bit is the step carry
  logic                             advance;

  assign advance       = executing && dda_tick;
  assign next_velocity = velocity + move.incrementincrement;
  assign sum           = {1'b0, accumulator} + {1'b0, next_velocity};

  // Integrator, loaded at every move start
  always_ff @(posedge CLK) begin
    if (loading) begin
      velocity    <= move.increment;
      accumulator <= '0;
    end else if (advance) begin
      velocity    <= next_velocity;
      accumulator <= sum[stepper_pkg::dda_bits-1:0];
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      dir      <= 1'b0;
      position <= '0;
    end else begin
      step <= advance & sum[stepper_pkg::dda_bits];
      if (loading) begin
        dir <= move.dir;
      end
      // Count tracks the step being issued
      if (advance && sum[stepper_pkg::dda_bits]) begin
        position <= dir ? position + 1'b1 : position - 1'b1;
      end
    end
  end

endmodule

// File: src/move_sequencer.sv
// Move sequencer: DDA tick divider, slot ready flags, duration counting and move events
`timescale 1ns/1ps

module move_sequencer #(
  parameter int buffer_size = 2,
  localparam int index_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic [stepper_pkg::divisor_bits-1:0]  clock_divisor,
  input  logic                                  buf_write,
  input  logic [index_bits-1:0]                 buf_index,
  input  logic [stepper_pkg::duration_bits-1:0] duration,
  output logic                                  dda_tick,
  output logic [index_bits-1:0]                 read_index,
  output logic                                  loading,
  output logic                                  executing,
  output logic                                  move_done,
  output logic                                  buffer_dtr
);

  localparam logic [index_bits-1:0] last_index = index_bits'(buffer_size - 1);

  logic [stepper_pkg::divisor_bits-1:0]  div_count;
  logic [buffer_size-1:0]                ready;      // One flag per committed slot
  logic [stepper_pkg::duration_bits-1:0] slot_duration [buffer_size];
  logic [stepper_pkg::duration_bits-1:0] remaining;  // Ticks left in the active move
  logic                                  last_tick;

  assign buffer_dtr = ~&ready;
  assign last_tick  = executing && dda_tick && (remaining <= 1);

  // Divisor of 0 or 1 ticks every cycle
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= '0;
      dda_tick  <= 1'b0;
    end else if (({1'b0, div_count} + 1'b1) >= {1'b0, clock_divisor}) begin
      div_count <= '0;
      dda_tick  <= 1'b1;
    end else begin
      div_count <= div_count + 1'b1;
      dda_tick  <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (buf_write) begin
      slot_duration[buf_index] <= duration;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      ready      <= '0;
      read_index <= '0;
      loading    <= 1'b0;
      executing  <= 1'b0;
      move_done  <= 1'b0;
      remaining  <= '0;
    end else begin
      loading   <= 1'b0;
      move_done <= 1'b0;

      // Start on the first tick that finds the current slot filled
      if (!executing && !loading && ready[read_index] && dda_tick) begin
        loading <= 1'b1;
      end

      if (loading) begin
        executing <= 1'b1;
        remaining <= slot_duration[read_index];
      end else if (last_tick) begin
        executing         <= 1'b0;
        move_done         <= 1'b1;
        ready[read_index] <= 1'b0;  // Slot free for the host again
        read_index        <= (read_index == last_index) ? '0 : read_index + 1'b1;
      end else if (executing && dda_tick) begin
        remaining <= remaining - 1'b1;
      end

      if (buf_write) begin
        ready[buf_index] <= 1'b1;
      end
    end
  end

  a_load_exclusive: assert property (
    @(posedge CLK) disable iff (resetn) !(loading && executing)
  );

  a_done_single: assert property (
    @(posedge CLK) disable iff (resetn) move_done |=> !move_done
  );

endmodule

// File: src/stepper_controller_top.sv
// Top level of the stepper command unit that a host drives through the word strobe handshake
`timescale 1ns/1ps

module stepper_controller_top #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2,
  localparam int index_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                              CLK,
  input  logic                              resetn,
  input  stepper_pkg::host_word_u           word_data,
  input  logic                              word_received,
  input  logic [num_motors-1:0]             fault,
  output logic [stepper_pkg::word_bits-1:0] word_send_data,
  output logic [num_motors-1:0]             step,
  output logic [num_motors-1:0]             dir,
  output logic [num_motors-1:0]             enable,
  output logic [num_motors-1:0]             brake,
  output logic                              buffer_dtr,
  output logic                              move_done
);

  logic [stepper_pkg::divisor_bits-1:0]  clock_divisor;
  logic                                  buf_write;
  logic [index_bits-1:0]                 buf_index;
  logic [stepper_pkg::duration_bits-1:0] duration;
  stepper_pkg::move_t                    move_slot [buffer_size][num_motors];
  logic [stepper_pkg::position_bits-1:0] positions [num_motors];
  logic                                  dda_tick;
  logic [index_bits-1:0]                 read_index;
  logic                                  loading;
  logic                                  executing;

  word_command_decoder #(.num_motors(num_motors), .buffer_size(buffer_size)) u_decoder (
    .CLK, .resetn, .word_data, .word_received, .fault, .positions,
    .word_send_data, .enable, .brake, .dir_write (), .clock_divisor,
    .buf_write, .buf_index, .duration, .move_slot
  );

  move_sequencer #(.buffer_size(buffer_size)) u_sequencer (
    .CLK, .resetn, .clock_divisor, .buf_write, .buf_index, .duration,
    .dda_tick, .read_index, .loading, .executing, .move_done, .buffer_dtr
  );

  for (genvar a = 0; a < num_motors; a++) begin : g_axis
    // Active slot chosen by the sequencer
    dda_axis u_dda_axis (
      .CLK, .resetn, .dda_tick, .loading, .executing,
      .move     (move_slot[read_index][a]),
      .step     (step[a]),
      .dir      (dir[a]),
      .position (positions[a])
    );
  end

endmodule

// File: src/stepper_pkg.sv
// Shared widths, command codes and host word layout, referenced by scoped name from the RTL
package stepper_pkg;

  // Datapath widths
  localparam int word_bits     = 64;
  localparam int dda_bits      = 64;  // Increment, velocity and accumulator
  localparam int duration_bits = 32;  // Move length in DDA ticks
  localparam int position_bits = 32;
  localparam int divisor_bits  = 8;

  // Reset value of the step-rate divider
  localparam int default_clock_divisor = 32;

  // Returned by the version read, one byte each
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd0;
  localparam logic [7:0] version_devel = 8'd1;

  // Command codes in the top byte of a header word
  typedef enum logic [7:0] {
    cmd_coordinated_step = 8'h01,
    cmd_motor_enable     = 8'h0a,
    cmd_motor_brake      = 8'h0b,
    cmd_clock_divisor    = 8'h20,
    cmd_stepper_fault    = 8'h50,
    cmd_api_version      = 8'hfe
  } cmd_e;

  // First word of a message
  typedef struct packed {
    logic [7:0]  cmd;
    logic [6:0]  reserved;
    logic        channel;   // Motor select of the dropped per-channel configs
    logic [47:0] payload;   // Masks, divisor or move directions in the low bits
  } header_t;

  // Header words use the struct view, continuation words the raw view
  typedef union packed {
    header_t              header;
    logic [word_bits-1:0] raw;
  } host_word_u;

  // One buffered move for one axis
  typedef struct packed {
    logic                dir;
    logic [dda_bits-1:0] increment;
    logic [dda_bits-1:0] incrementincrement;
  } move_t;

endpackage

// File: src/word_command_decoder.sv
// Host word decoder: strobe edge detect, control registers, move buffer writes and reply words
`timescale 1ns/1ps

module word_command_decoder #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2,
  localparam int index_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                                     CLK,
  input  logic                                     resetn,
  input  stepper_pkg::host_word_u                  word_data,
  input  logic                                     word_received,
  input  logic [num_motors-1:0]                    fault,
  input  logic [stepper_pkg::position_bits-1:0]    positions [num_motors],
  output logic [stepper_pkg::word_bits-1:0]        word_send_data,
  output logic [num_motors-1:0]                    enable,
  output logic [num_motors-1:0]                    brake,
  output logic [num_motors-1:0]                    dir_write,
  output logic [stepper_pkg::divisor_bits-1:0]     clock_divisor,
  output logic                                     buf_write,
  output logic [index_bits-1:0]                    buf_index,
  output logic [stepper_pkg::duration_bits-1:0]    duration,
  output stepper_pkg::move_t                       move_slot [buffer_size][num_motors]
);

  localparam logic [index_bits-1:0] last_index = index_bits'(buffer_size - 1);
  localparam logic [7:0] last_word_count = 8'(2 * num_motors + 1);

  logic [2:0] strobe_sync;  // Two sync stages plus the edge reference
  logic       strobe_rise;
  logic       in_move;      // Inside a coordinated move, next word is raw data
  logic [7:0] word_count;   // Continuation words seen, duration word is 1
  logic       header_word;
  logic       move_word;
  logic       last_word;
  logic [index_bits-1:0] write_index;

  // Positions taken at the move header, replayed during the continuation words
  logic [stepper_pkg::position_bits-1:0] snapshot [num_motors];

  assign strobe_rise = strobe_sync[1] & ~strobe_sync[2];
  assign header_word = strobe_rise & ~in_move;
  assign move_word   = strobe_rise & in_move;
  assign last_word   = move_word && (word_count == last_word_count);

  // Control state and replies
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_sync    <= '0;
      word_send_data <= '0;
      enable         <= '0;
      brake          <= '0;
      clock_divisor  <= stepper_pkg::divisor_bits'(stepper_pkg::default_clock_divisor);
      in_move        <= 1'b0;
      word_count     <= '0;
      write_index    <= '0;
      buf_write      <= 1'b0;
      buf_index      <= '0;
    end else begin
      strobe_sync <= {strobe_sync[1:0], word_received};
      buf_write   <= 1'b0;

      if (header_word) begin
        word_send_data <= '0;  // Anything not listed replies zero
        case (word_data.header.cmd)
          stepper_pkg::cmd_coordinated_step: begin
            in_move    <= 1'b1;
            word_count <= 8'd1;
          end
          stepper_pkg::cmd_motor_enable: enable <= word_data.header.payload[num_motors-1:0];
          stepper_pkg::cmd_motor_brake:  brake  <= word_data.header.payload[num_motors-1:0];
          stepper_pkg::cmd_clock_divisor: begin
            clock_divisor <= word_data.header.payload[stepper_pkg::divisor_bits-1:0];
          end
          stepper_pkg::cmd_stepper_fault: begin
            word_send_data[num_motors-1:0] <= fault;
          end
          stepper_pkg::cmd_api_version: begin
            word_send_data[31:0] <= {stepper_pkg::version_devel, stepper_pkg::version_major,
                                     stepper_pkg::version_minor, stepper_pkg::version_patch};
          end
          default: word_send_data <= '0;
        endcase
      end else if (move_word) begin
        word_count     <= word_count + 8'd1;
        word_send_data <= '0;  // Increment words carry no position

        // Duration word returns axis 0, incrementincrement of axis a returns axis a+1
        if (word_count == 8'd1) begin
          word_send_data <= stepper_pkg::word_bits'(snapshot[0]);
        end
        for (int a = 0; a < num_motors - 1; a++) begin
          if (word_count == 8'(2 * a + 3)) begin
            word_send_data <= stepper_pkg::word_bits'(snapshot[a+1]);
          end
        end

        if (last_word) begin
          in_move     <= 1'b0;
          word_count  <= '0;
          buf_write   <= 1'b1;
          buf_index   <= write_index;
          write_index <= (write_index == last_index) ? '0 : write_index + 1'b1;
        end
      end
    end
  end

  // Move payload and position snapshot
  always_ff @(posedge CLK) begin
    if (header_word && word_data.header.cmd == stepper_pkg::cmd_coordinated_step) begin
      dir_write <= word_data.header.payload[num_motors-1:0];
      for (int a = 0; a < num_motors; a++) begin
        snapshot[a] <= positions[a];
      end
    end

    if (move_word) begin
      if (word_count == 8'd1) begin
        duration <= word_data.raw[stepper_pkg::duration_bits-1:0];
      end
      for (int a = 0; a < num_motors; a++) begin
        if (word_count == 8'(2 * a + 2)) begin
          move_slot[write_index][a].increment <= word_data.raw;
        end
        if (word_count == 8'(2 * a + 3)) begin
          move_slot[write_index][a].incrementincrement <= word_data.raw;
        end
        if (last_word) begin
          move_slot[write_index][a].dir <= dir_write[a];  // Direction lands with the commit
        end
      end
    end
  end

  a_buf_index_range: assert property (
    @(posedge CLK) disable iff (resetn) buf_write |-> (int'(buf_index) < buffer_size)
  );

endmodule

// File: verif/tb_stepper_controller.sv
// Random-command testbench for the stepper command unit that runs as the simulation top from compile.f
`timescale 1ns/1ps

module tb_stepper_controller;

  localparam int num_motors     = 2;
  localparam int buffer_size    = 2;
  localparam int clock_period   = 8;
  localparam int num_seq_moves  = 12;
  localparam int num_queued     = 3;  // Pairs of back-to-back moves
  localparam int total_moves    = num_seq_moves + 2 + 2 * num_queued;
  localparam int max_duration   = 16;
  localparam int max_divisor    = 32;
  localparam int move_cycles    = max_duration * max_divisor + (2 * num_motors + 3) * 8;
  localparam int timeout_cycles = total_moves * move_cycles + 1000;

  typedef struct packed {
    logic [stepper_pkg::duration_bits-1:0] duration;
    stepper_pkg::move_t [num_motors-1:0]   axis;
  } move_spec_t;

  typedef struct packed {
    logic [num_motors-1:0]                                 dir;
    logic [num_motors-1:0][stepper_pkg::position_bits-1:0] steps;
  } outcome_t;

  logic                                  CLK;
  logic                                  resetn;
  stepper_pkg::host_word_u               word_data;
  logic                                  word_received;
  logic [num_motors-1:0]                 fault;
  logic [stepper_pkg::word_bits-1:0]     word_send_data;
  logic [num_motors-1:0]                 step;
  logic [num_motors-1:0]                 dir;
  logic [num_motors-1:0]                 enable;
  logic [num_motors-1:0]                 brake;
  logic                                  buffer_dtr;
  logic                                  move_done;
  logic [15:0]                           lfsr_state;
  logic [stepper_pkg::position_bits-1:0] model_pos [num_motors];
  logic [stepper_pkg::position_bits-1:0] step_count [num_motors];
  outcome_t                              expected_q [$];  // Moves written and not yet done
  int                                    done_count;
  int                                    moves_sent;

  stepper_controller_top #(.num_motors(num_motors), .buffer_size(buffer_size))
  u_stepper_controller_top (
    .CLK, .resetn, .word_data, .word_received, .fault, .word_send_data,
    .step, .dir, .enable, .brake, .buffer_dtr, .move_done
  );

  initial CLK = 1'b0;
  always #(clock_period / 2) CLK = ~CLK;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare_reply(input string name, input stepper_pkg::host_word_u expected,
                               input stepper_pkg::host_word_u actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected.raw, actual.raw);
      abort_run();
    end
  endtask

  task automatic compare_mask(input string name, input logic [num_motors-1:0] expected,
                              input logic [num_motors-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %b actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name,
                               input logic [stepper_pkg::position_bits-1:0] expected,
                               input logic [stepper_pkg::position_bits-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %0d actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [63:0] rand_bits(input int count);
    logic [63:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], feedback};
      value      = {value[62:0], feedback};
    end
    return value;
  endfunction

  function automatic stepper_pkg::host_word_u make_header(input stepper_pkg::cmd_e cmd,
                                                          input logic [47:0] payload);
    stepper_pkg::host_word_u word;
    word.raw            = '0;
    word.header.cmd     = cmd;
    word.header.payload = payload;
    return word;
  endfunction

  function automatic move_spec_t random_move(input int min_duration, input int spread_bits);
    move_spec_t spec;
    spec.duration = 32'(min_duration) + 32'(rand_bits(spread_bits));
    for (int a = 0; a < num_motors; a++) begin
      spec.axis[a].dir                = rand_bits(1);
      spec.axis[a].increment          = rand_bits(62);  // Roughly one step every few ticks
      spec.axis[a].incrementincrement = rand_bits(56);
    end
    return spec;
  endfunction

  // Reference DDA adds velocity first and steps on a carry out of bit 63
  function automatic outcome_t integrate_move(input move_spec_t spec);
    outcome_t                         result;
    logic [stepper_pkg::dda_bits-1:0] velocity;
    logic [stepper_pkg::dda_bits:0]   accumulator;
    result = '0;
    for (int a = 0; a < num_motors; a++) begin
      velocity      = spec.axis[a].increment;
      accumulator   = '0;
      result.dir[a] = spec.axis[a].dir;
      for (int t = 0; t < int'(spec.duration); t++) begin
        velocity    = velocity + spec.axis[a].incrementincrement;
        accumulator = {1'b0, accumulator[63:0]} + {1'b0, velocity};
        if (accumulator[64]) begin
          result.steps[a] = result.steps[a] + 1'b1;
        end
      end
    end
    return result;
  endfunction

  // Strobe high for 4 cycles and low for 2
  task automatic send_word(input stepper_pkg::host_word_u word,
                           output stepper_pkg::host_word_u reply);
    @(negedge CLK);
    word_data     = word;
    word_received = 1'b1;
    repeat (4) @(negedge CLK);
    word_received = 1'b0;
    reply         = word_send_data;
    repeat (2) @(negedge CLK);
  endtask

  task automatic set_divisor(input logic [stepper_pkg::divisor_bits-1:0] divisor);
    stepper_pkg::host_word_u reply;
    stepper_pkg::host_word_u zero;
    zero.raw = '0;
    send_word(make_header(stepper_pkg::cmd_clock_divisor, 48'(divisor)), reply);
    compare_reply("divisor write reply", zero, reply);
  endtask

  // Position replies only hold when no move runs during the header
  task automatic send_move(input move_spec_t spec, input bit check_positions);
    stepper_pkg::host_word_u               word;
    stepper_pkg::host_word_u               reply;
    stepper_pkg::host_word_u               expected;
    logic [stepper_pkg::position_bits-1:0] snapshot [num_motors];
    outcome_t                              outcome;
    logic [47:0]                           dirs;
    dirs    = '0;
    outcome = integrate_move(spec);
    expected_q.push_back(outcome);
    moves_sent++;
    for (int a = 0; a < num_motors; a++) begin
      dirs[a]      = spec.axis[a].dir;
      snapshot[a]  = model_pos[a];
      model_pos[a] = spec.axis[a].dir ? model_pos[a] + outcome.steps[a]
                                      : model_pos[a] - outcome.steps[a];
    end
    expected.raw = '0;
    send_word(make_header(stepper_pkg::cmd_coordinated_step, dirs), reply);
    compare_reply("move header reply", expected, reply);
    word.raw = 64'(spec.duration);
    send_word(word, reply);
    expected.raw = 64'(snapshot[0]);
    if (check_positions) begin
      compare_reply("position reply axis 0", expected, reply);
    end
    for (int a = 0; a < num_motors; a++) begin
      word.raw = spec.axis[a].increment;
      send_word(word, reply);
      expected.raw = '0;
      compare_reply($sformatf("increment reply axis %0d", a), expected, reply);
      word.raw = spec.axis[a].incrementincrement;
      send_word(word, reply);
      if (a < num_motors - 1) begin
        expected.raw = 64'(snapshot[a + 1]);
      end
      if (check_positions || a == num_motors - 1) begin
        compare_reply($sformatf("position reply axis %0d", a + 1), expected, reply);
      end
    end
  endtask

  // Step counts are checked and cleared at each move_done
  always @(negedge CLK) begin
    outcome_t expected;
    if (!resetn) begin
      for (int a = 0; a < num_motors; a++) begin
        if (step[a]) step_count[a] = step_count[a] + 1'b1;
      end
      if (move_done && expected_q.size() == 0) begin
        $display("move_done pulsed with no move outstanding");
        abort_run();
      end else if (move_done) begin
        expected = expected_q.pop_front();
        for (int a = 0; a < num_motors; a++) begin
          compare_count($sformatf("move %0d steps axis %0d", done_count, a),
                        expected.steps[a], step_count[a]);
          step_count[a] = '0;
        end
        compare_mask($sformatf("move %0d dir", done_count), expected.dir, dir);
        done_count++;
      end
    end
  end

  initial begin
    #(timeout_cycles * clock_period);
    $display("Timeout with %0d of %0d moves done", done_count, moves_sent);
    abort_run();
  end

  initial begin
    stepper_pkg::host_word_u reply;
    stepper_pkg::host_word_u expected;
    logic [47:0]             payload;
    move_spec_t              spec;
    lfsr_state    = 16'd62;
    resetn        = 1'b1;
    word_received = 1'b0;
    word_data     = '0;
    fault         = '0;
    done_count    = 0;
    moves_sent    = 0;
    for (int a = 0; a < num_motors; a++) begin
      model_pos[a]  = '0;
      step_count[a] = '0;
    end
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);
    expected.raw = '0;
    compare_reply("reset reply", expected, word_send_data);
    compare_mask("reset step", '0, step);
    compare_mask("reset enable", '0, enable);
    compare_mask("reset brake", '0, brake);
    if (!buffer_dtr || move_done) begin
      $display("buffer_dtr low or move_done high after reset");
      abort_run();
    end

    for (int i = 0; i < 4; i++) begin
      send_word(make_header(stepper_pkg::cmd_api_version, rand_bits(48)), reply);
      expected.raw        = '0;
      expected.raw[7:0]   = stepper_pkg::version_patch;
      expected.raw[15:8]  = stepper_pkg::version_minor;
      expected.raw[23:16] = stepper_pkg::version_major;
      expected.raw[31:24] = stepper_pkg::version_devel;
      compare_reply("version read", expected, reply);
      fault = rand_bits(num_motors);
      send_word(make_header(stepper_pkg::cmd_stepper_fault, '0), reply);
      expected.raw = 64'(fault);
      compare_reply("fault read", expected, reply);
    end

    for (int i = 0; i < 4; i++) begin
      expected.raw = '0;
      payload = rand_bits(48);
      send_word(make_header(stepper_pkg::cmd_motor_enable, payload), reply);
      compare_reply("enable write reply", expected, reply);
      compare_mask("enable mask", payload[num_motors-1:0], enable);
      payload = rand_bits(48);
      send_word(make_header(stepper_pkg::cmd_motor_brake, payload), reply);
      compare_reply("brake write reply", expected, reply);
      compare_mask("brake mask", payload[num_motors-1:0], brake);
    end

    // One move at a time with a random divisor each
    for (int i = 0; i < num_seq_moves; i++) begin
      set_divisor(8'(rand_bits(5) + 1));
      send_move(random_move(1, 4), 1'b1);
      wait (done_count == moves_sent);
    end

    // Same move under two divisors
    spec = random_move(4, 3);
    set_divisor(8'd3);
    send_move(spec, 1'b1);
    wait (done_count == moves_sent);
    set_divisor(8'd29);
    send_move(spec, 1'b1);
    wait (done_count == moves_sent);

    // Long first move keeps the buffer full while the second is written
    for (int i = 0; i < num_queued; i++) begin
      set_divisor(8'd16);
      send_move(random_move(8, 3), 1'b1);
      if (!buffer_dtr) begin
        $display("buffer_dtr low with one slot still free");
        abort_run();
      end
      send_move(random_move(1, 4), 1'b0);
      if (buffer_dtr) begin
        $display("buffer_dtr high with both slots full");
        abort_run();
      end
      wait (done_count == moves_sent - 1);
      if (!buffer_dtr) begin
        $display("buffer_dtr still low after move_done");
        abort_run();
      end
      wait (done_count == moves_sent);
    end

    repeat (20) @(negedge CLK);
    if (expected_q.size() != 0 || done_count != moves_sent) begin
      $display("Moves left unfinished at the end of the run");
      abort_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule
